// ==== list.f ====
source/isaPkg.sv
source/ctrlPkg.sv
source/controller.sv
source/registerFile.sv
source/immExtend.sv
source/alu.sv
source/hazardUnit.sv
source/datapath.sv
source/riscvCore.sv
sim/tbCore.sv

// ==== sim/tbCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbCore;

    localparam logic [31:0] resetAddress = 32'h0000_0100;
    localparam logic [31:0] poisonAddr   = 32'h0000_00f0;
    localparam logic [31:0] doneAddr     = 32'h0000_00fc;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] pc, instr, dataAddr, writeData, readData;
    logic        memWrite;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] xr [32];
    logic [31:0] expData [64];
    string       storeName [64];
    logic [63:0] wantMask = '0;
    logic [63:0] seenMask = '0;
    logic [31:0] straightEnd, expPc;
    integer      seed;
    int          ptr, progLen = 0, branchIdx = 0, cycles = 0, errors = 0;

    riscvCore #(.resetAddress(resetAddress)) DUT (
        .clk(clk), .rst(rst), .pc(pc), .instr(instr),
        .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite),
        .readData(readData)
    );

    always #10 clk = ~clk;

    // both memories answer from the addresses of the current cycle
    always @(negedge clk) begin
        instr    <= imem[pc[9:2]];
        readData <= dmem[dataAddr[7:2]];
    end

    // straight-line fetch order from reset
    always @(posedge clk) begin
        cycles <= cycles + 1;
        expPc  <= rst ? resetAddress : expPc + 32'd4;
        if (memWrite) begin
            dmem[dataAddr[7:2]]     <= writeData;
            seenMask[dataAddr[7:2]] <= 1'b1;
        end
    end

    function automatic isaPkg::instrWord rWord(input logic [2:0] f3, input logic f7b5,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        isaPkg::instrWord w;
        w.r = '{{1'b0, f7b5, 5'b0}, rs2, rs1, f3, rd, isaPkg::opReg};
        return w;
    endfunction

    function automatic isaPkg::instrWord iWord(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        isaPkg::instrWord w;
        w.i = '{imm, rs1, f3, rd, op};
        return w;
    endfunction

    function automatic isaPkg::instrWord sWord(input logic [4:0] rs2, input logic [4:0] rs1,
            input logic [11:0] off);
        isaPkg::instrWord w;
        w.s = '{off[11:5], rs2, rs1, 3'b010, off[4:0], isaPkg::opStore};
        return w;
    endfunction

    function automatic isaPkg::instrWord bWord(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] off);
        isaPkg::instrWord w;
        w.b = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], isaPkg::opBranch};
        return w;
    endfunction

    function automatic isaPkg::instrWord jWord(input logic [4:0] rd, input logic [20:0] off);
        isaPkg::instrWord w;
        w.j = '{off[20], off[10:1], off[11], off[19:12], rd, isaPkg::opJal};
        return w;
    endfunction

    function automatic isaPkg::instrWord uWord(input logic [4:0] rd, input logic [19:0] imm);
        isaPkg::instrWord w;
        w.u = '{imm, rd, isaPkg::opLui};
        return w;
    endfunction

    function automatic logic [11:0] rnd12();
        return 12'($random(seed));
    endfunction

    // integer results as the instruction set defines them
    function automatic logic [31:0] applyOp(input logic [2:0] f3, input logic sub,
            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'd0;
        endcase
    endfunction

    task automatic place(input isaPkg::instrWord w);
        imem[ptr] = w;
        ptr++;
    endtask

    task automatic arith(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        place(rWord(f3, sub, rd, rs1, rs2));
        xr[rd] = applyOp(f3, sub, xr[rs1], xr[rs2]);
    endtask

    task automatic arithImm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [11:0] imm);
        place(iWord(imm, rs1, f3, rd, isaPkg::opImm));
        xr[rd] = applyOp(f3, 1'b0, xr[rs1], {{20{imm[11]}}, imm});
    endtask

    task automatic storeTo(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] off,
            input string name);
        logic [31:0] addr;
        addr = xr[rs1] + {{20{off[11]}}, off};
        place(sWord(rs2, rs1, off));
        expData[addr[7:2]]   = xr[rs2];
        wantMask[addr[7:2]]  = 1'b1;
        storeName[addr[7:2]] = name;
    endtask

    task automatic loadFrom(input logic [4:0] rd, input logic [11:0] off);
        place(iWord(off, 5'd0, 3'b010, rd, isaPkg::opLoad));
        xr[rd] = dmem[off[7:2]];
    endtask

    // a taken branch skips the poison store
    // the fall-through store carries a marker
    task automatic branchOver(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
            input string name);
        logic        taken;
        logic [11:0] fall;
        fall = 12'h080 + 12'(branchIdx * 8);
        case (f3)
            3'b000:  taken = (xr[rs1] == xr[rs2]);
            3'b001:  taken = (xr[rs1] != xr[rs2]);
            3'b100:  taken = ($signed(xr[rs1]) < $signed(xr[rs2]));
            default: taken = ($signed(xr[rs1]) >= $signed(xr[rs2]));
        endcase
        place(bWord(f3, rs1, rs2, 13'd8));
        if (taken) begin
            place(sWord(5'd17, 5'd0, poisonAddr[11:0]));
        end else begin
            storeTo(5'd17, 5'd0, fall, {name, " fall-through"});
        end
        storeTo(5'd17, 5'd0, fall + 12'd4, {name, " target"});
        branchIdx++;
    endtask

    task automatic buildProgram();
        logic [19:0] imm20;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = iWord(12'd0, 5'd0, 3'b000, 5'd0, isaPkg::opImm);
        end
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        ptr = resetAddress[9:2];
        arithImm(3'b000, 5'd1, 5'd0, rnd12());
        arithImm(3'b000, 5'd2, 5'd1, rnd12());
        arith(3'b000, 1'b0, 5'd3, 5'd1, 5'd2);
        storeTo(5'd3, 5'd0, 12'h040, "add");
        arith(3'b000, 1'b1, 5'd4, 5'd3, 5'd1);
        storeTo(5'd4, 5'd0, 12'h044, "sub");
        arith(3'b111, 1'b0, 5'd5, 5'd4, 5'd2);
        storeTo(5'd5, 5'd0, 12'h048, "and");
        arith(3'b110, 1'b0, 5'd6, 5'd5, 5'd3);
        storeTo(5'd6, 5'd0, 12'h04c, "or");
        arith(3'b010, 1'b0, 5'd7, 5'd4, 5'd1);
        storeTo(5'd7, 5'd0, 12'h050, "slt");
        arithImm(3'b111, 5'd8, 5'd6, rnd12());
        storeTo(5'd8, 5'd0, 12'h054, "andi");
        arithImm(3'b110, 5'd9, 5'd8, rnd12());
        storeTo(5'd9, 5'd0, 12'h058, "ori");
        arithImm(3'b010, 5'd10, 5'd9, rnd12());
        storeTo(5'd10, 5'd0, 12'h05c, "slti");
        arithImm(3'b000, 5'd11, 5'd0, 12'h060);
        storeTo(5'd2, 5'd11, 12'h004, "addi base");
        straightEnd = ptr * 4;
        loadFrom(5'd12, 12'h000);
        arith(3'b000, 1'b0, 5'd13, 5'd12, 5'd1);
        storeTo(5'd13, 5'd0, 12'h068, "load-use add");
        loadFrom(5'd14, 12'h004);
        storeTo(5'd14, 5'd0, 12'h06c, "load-use store");
        arithImm(3'b000, 5'd17, 5'd0, 12'h5a5);
        arithImm(3'b000, 5'd15, 5'd0, 12'd5);
        arithImm(3'b000, 5'd16, 5'd0, -12'sd3);
        arithImm(3'b000, 5'd18, 5'd0, 12'd5);
        branchOver(3'b000, 5'd15, 5'd18, "beq taken");
        branchOver(3'b000, 5'd15, 5'd16, "beq not taken");
        branchOver(3'b001, 5'd15, 5'd16, "bne taken");
        branchOver(3'b001, 5'd15, 5'd18, "bne not taken");
        branchOver(3'b100, 5'd16, 5'd15, "blt taken");
        branchOver(3'b100, 5'd15, 5'd16, "blt not taken");
        branchOver(3'b101, 5'd15, 5'd16, "bge taken");
        branchOver(3'b101, 5'd16, 5'd15, "bge not taken");
        xr[19] = ptr * 4 + 4;
        place(jWord(5'd19, 21'd8));
        place(sWord(5'd0, 5'd0, poisonAddr[11:0]));
        storeTo(5'd19, 5'd0, 12'h0c0, "jal link");
        // jalr lands past itself and one poison store
        arithImm(3'b000, 5'd20, 5'd0, 12'(ptr * 4 + 12));
        xr[21] = ptr * 4 + 4;
        place(iWord(12'd0, 5'd20, 3'b000, 5'd21, isaPkg::opJalr));
        place(sWord(5'd0, 5'd0, poisonAddr[11:0]));
        storeTo(5'd21, 5'd0, 12'h0c4, "jalr link");
        imm20 = $random(seed);
        place(uWord(5'd22, imm20));
        xr[22] = {imm20, 12'b0};
        storeTo(5'd22, 5'd0, 12'h0c8, "lui");
        place(sWord(5'd17, 5'd0, doneAddr[11:0]));
        progLen = ptr - int'(resetAddress[9:2]);
    endtask

    resetState: assert property (@(posedge clk) rst && cycles > 0 |->
            pc == resetAddress && !memWrite)
        else begin
            errors++;
            $display("FAIL reset expected pc=%h memWrite=0 actual pc=%h memWrite=%b",
                     resetAddress, $sampled(pc), $sampled(memWrite));
        end

    resetExit: assert property (@(posedge clk) $fell(rst) |-> pc == resetAddress && !memWrite)
        else begin
            errors++;
            $display("FAIL first cycle expected pc=%h memWrite=0 actual pc=%h memWrite=%b",
                     resetAddress, $sampled(pc), $sampled(memWrite));
        end

    pcStep: assert property (@(posedge clk) disable iff (rst)
            expPc < straightEnd |-> pc == expPc)
        else begin
            errors++;
            $display("FAIL pc step expected %h actual %h", $sampled(expPc), $sampled(pc));
        end

    storeValue: assert property (@(posedge clk) disable iff (rst)
            memWrite && dataAddr[31:8] == 24'd0 && wantMask[dataAddr[7:2]] |->
            writeData == expData[dataAddr[7:2]])
        else begin
            errors++;
            $display("FAIL %s expected %h actual %h", storeName[$sampled(dataAddr[7:2])],
                     expData[$sampled(dataAddr[7:2])], $sampled(writeData));
        end

    storeKnown: assert property (@(posedge clk) disable iff (rst)
            memWrite && dataAddr != poisonAddr |-> dataAddr == doneAddr ||
            (dataAddr[31:8] == 24'd0 && dataAddr[1:0] == 2'b00 && wantMask[dataAddr[7:2]]))
        else begin
            errors++;
            $display("store to an unexpected address %h", $sampled(dataAddr));
        end

    poisonStore: assert property (@(posedge clk) disable iff (rst)
            memWrite |-> dataAddr != poisonAddr)
        else begin
            errors++;
            $display("a skipped instruction stored to the poison address");
        end

    allStores: assert property (@(posedge clk) disable iff (rst)
            memWrite && dataAddr == doneAddr |-> (seenMask & wantMask) == wantMask)
        else begin
            errors++;
            $display("program finished with expected stores missing, mask %h",
                     wantMask & ~$sampled(seenMask));
        end

    initial begin
        rst      = 1'b1;
        instr    = 32'h0000_0013;
        readData = '0;
        seed     = 32'h9f863a4b;
        buildProgram();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        do begin
            @(negedge clk);
        end while (!(memWrite && dataAddr == doneAddr));
        repeat (2) @(negedge clk);
        $display("checks failed: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // budget of four cycles per instruction plus margin
    initial begin
        wait (progLen != 0 && rst === 1'b0);
        repeat (progLen * 4 + 50) @(posedge clk);
        $display("timeout: the program did not finish within %0d cycles", progLen * 4 + 50);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  ctrlPkg::aluCtrl aluControl,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    output logic [31:0]     result,
    output logic            zero,
    output logic            neg
);

    always_comb begin
        case (aluControl)
            ctrlPkg::aluAdd: result = a + b;
            ctrlPkg::aluSub: result = a - b;
            ctrlPkg::aluAnd: result = a & b;
            ctrlPkg::aluOr:  result = a | b;
            ctrlPkg::aluSlt: result = {31'b0, $signed(a) < $signed(b)};
            default:         result = '0;
        endcase
    end

    // flags feed branch resolution
    assign zero = (result == 32'd0);
    assign neg  = result[31];

endmodule

`default_nettype wire

// ==== source/controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module controller (
    input  logic [6:0]         op,
    input  logic [2:0]         funct3,
    input  logic               funct7b5,
    output logic               regWriteD,
    output logic               memWriteD,
    output logic               aluSrcD,
    output logic               jumpD,
    output logic               jumpRegD,
    output ctrlPkg::resultSrc  resultSrcD,
    output ctrlPkg::aluCtrl    aluControlD,
    output ctrlPkg::branchKind branchD,
    output ctrlPkg::immKind    immSrcD
);

    function automatic ctrlPkg::aluCtrl decodeAlu(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b010:  return ctrlPkg::aluSlt;
            3'b110:  return ctrlPkg::aluOr;
            3'b111:  return ctrlPkg::aluAnd;
            default: return sub ? ctrlPkg::aluSub : ctrlPkg::aluAdd;
        endcase
    endfunction

    always_comb begin
        regWriteD   = 1'b0;
        memWriteD   = 1'b0;
        aluSrcD     = 1'b0;
        jumpD       = 1'b0;
        jumpRegD    = 1'b0;
        resultSrcD  = ctrlPkg::resAlu;
        aluControlD = ctrlPkg::aluAdd;
        branchD     = ctrlPkg::brNone;
        immSrcD     = ctrlPkg::immI;
        case (op)
            isaPkg::opReg: begin
                regWriteD   = 1'b1;
                aluControlD = decodeAlu(funct3, funct7b5);
            end
            isaPkg::opImm: begin
                regWriteD   = 1'b1;
                aluSrcD     = 1'b1;
                // no subi, funct7 field is immediate here
                aluControlD = decodeAlu(funct3, 1'b0);
            end
            isaPkg::opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = ctrlPkg::resMem;
            end
            isaPkg::opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD   = ctrlPkg::immS;
            end
            isaPkg::opBranch: begin
                aluControlD = ctrlPkg::aluSub;
                immSrcD     = ctrlPkg::immB;
                case (funct3)
                    3'b000:  branchD = ctrlPkg::brEq;
                    3'b001:  branchD = ctrlPkg::brNe;
                    3'b100:  branchD = ctrlPkg::brLt;
                    3'b101:  branchD = ctrlPkg::brGe;
                    default: branchD = ctrlPkg::brNone;
                endcase
            end
            isaPkg::opJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                resultSrcD = ctrlPkg::resPcPlus4;
                immSrcD    = ctrlPkg::immJ;
            end
            isaPkg::opJalr: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                jumpRegD   = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = ctrlPkg::resPcPlus4;
            end
            isaPkg::opLui: begin
                regWriteD  = 1'b1;
                resultSrcD = ctrlPkg::resImm;
                immSrcD    = ctrlPkg::immU;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluCtrl;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPcPlus4,
        resImm
    } resultSrc;

    // pcAlu is the jalr target
    typedef enum logic [1:0] {
        pcNext,
        pcTarget,
        pcAlu
    } pcSrc;

    typedef enum logic [2:0] {
        brNone,
        brEq,
        brNe,
        brLt,
        brGe
    } branchKind;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immKind;

    typedef enum logic [1:0] {
        fwdReg,
        fwdWriteback,
        fwdMemory
    } forwardSel;

endpackage

`default_nettype wire

// ==== source/datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module datapath #(
    parameter logic [31:0] resetAddress = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               regWriteD,
    input  logic               memWriteD,
    input  logic               aluSrcD,
    input  logic               jumpD,
    input  logic               jumpRegD,
    input  ctrlPkg::resultSrc  resultSrcD,
    input  ctrlPkg::aluCtrl    aluControlD,
    input  ctrlPkg::branchKind branchD,
    input  ctrlPkg::immKind    immSrcD,
    output logic [6:0]         op,
    output logic [2:0]         funct3,
    output logic               funct7b5,
    output logic [31:0]        pc,
    input  logic [31:0]        instr,
    output logic [31:0]        dataAddr,
    output logic [31:0]        writeData,
    output logic               memWrite,
    input  logic [31:0]        readData
);

    logic               stallF, stallD, flushD, flushE;
    ctrlPkg::forwardSel forwardAE, forwardBE;
    ctrlPkg::pcSrc      pcSrcE;

    logic [31:0] pcF, pcPlus4F, pcNextF;

    isaPkg::instrWord instrD;
    logic [31:0]      pcD, pcPlus4D, rd1D, rd2D, immD;

    logic               regWriteE, memWriteE, jumpE, jumpRegE, aluSrcE, takenE;
    ctrlPkg::resultSrc  resultSrcE;
    ctrlPkg::aluCtrl    aluControlE;
    ctrlPkg::branchKind branchE;
    logic [4:0]         rs1E, rs2E, rdE;
    logic [31:0]        rd1E, rd2E, pcE, pcPlus4E, immE;
    logic [31:0]        srcAE, srcBE, writeDataE, aluResultE, pcTargetE;
    logic               zeroE, negE;

    logic              regWriteM, memWriteM;
    ctrlPkg::resultSrc resultSrcM;
    logic [4:0]        rdM;
    logic [31:0]       aluResultM, writeDataM, pcPlus4M, immM, fwdValueM;

    logic              regWriteW;
    ctrlPkg::resultSrc resultSrcW;
    logic [4:0]        rdW;
    logic [31:0]       aluResultW, readDataW, pcPlus4W, immW, resultW;

    // fetch
    assign pcPlus4F = pcF + 32'd4;
    assign pc       = pcF;

    always_comb begin
        case (pcSrcE)
            ctrlPkg::pcTarget: pcNextF = pcTargetE;
            ctrlPkg::pcAlu:    pcNextF = {aluResultE[31:1], 1'b0};
            default:           pcNextF = pcPlus4F;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcF <= resetAddress;
        end else if (!stallF) begin
            pcF <= pcNextF;
        end
    end

    // decode, an all-zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || flushD) begin
            instrD <= '0;
        end else if (!stallD) begin
            instrD <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

    assign op       = instrD.r.op;
    assign funct3   = instrD.r.funct3;
    assign funct7b5 = instrD.r.funct7[5];

    registerFile regFile (
        .clk(clk), .regWrite(regWriteW),
        .readRegister1(instrD.r.rs1), .readRegister2(instrD.r.rs2),
        .writeRegister(rdW), .writeData(resultW),
        .readData1(rd1D), .readData2(rd2D)
    );

    immExtend extend (.instr(instrD), .immSrc(immSrcD), .imm(immD));

    // execute
    always_ff @(posedge clk) begin
        if (rst || flushE) begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            jumpE      <= 1'b0;
            jumpRegE   <= 1'b0;
            branchE    <= ctrlPkg::brNone;
            resultSrcE <= ctrlPkg::resAlu;
        end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            jumpE      <= jumpD;
            jumpRegE   <= jumpRegD;
            branchE    <= branchD;
            resultSrcE <= resultSrcD;
        end
    end

    always_ff @(posedge clk) begin
        aluControlE <= aluControlD;
        aluSrcE     <= aluSrcD;
        rs1E        <= instrD.r.rs1;
        rs2E        <= instrD.r.rs2;
        rdE         <= instrD.r.rd;
        rd1E        <= rd1D;
        rd2E        <= rd2D;
        pcE         <= pcD;
        pcPlus4E    <= pcPlus4D;
        immE        <= immD;
    end

    always_comb begin
        case (forwardAE)
            ctrlPkg::fwdMemory:    srcAE = fwdValueM;
            ctrlPkg::fwdWriteback: srcAE = resultW;
            default:               srcAE = rd1E;
        endcase
        case (forwardBE)
            ctrlPkg::fwdMemory:    writeDataE = fwdValueM;
            ctrlPkg::fwdWriteback: writeDataE = resultW;
            default:               writeDataE = rd2E;
        endcase
    end

    assign srcBE     = aluSrcE ? immE : writeDataE;
    assign pcTargetE = pcE + immE;

    alu mainAlu (
        .aluControl(aluControlE), .a(srcAE), .b(srcBE),
        .result(aluResultE), .zero(zeroE), .neg(negE)
    );

    // signed compare from the sign of a - b
    always_comb begin
        case (branchE)
            ctrlPkg::brEq: takenE = zeroE;
            ctrlPkg::brNe: takenE = !zeroE;
            ctrlPkg::brLt: takenE = negE;
            ctrlPkg::brGe: takenE = !negE;
            default:       takenE = 1'b0;
        endcase
    end

    always_comb begin
        if (jumpE) begin
            pcSrcE = jumpRegE ? ctrlPkg::pcAlu : ctrlPkg::pcTarget;
        end else begin
            pcSrcE = takenE ? ctrlPkg::pcTarget : ctrlPkg::pcNext;
        end
    end

    hazardUnit hazard (
        .rs1D(instrD.r.rs1), .rs2D(instrD.r.rs2),
        .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE), .rdM(rdM), .rdW(rdW),
        .regWriteM(regWriteM), .regWriteW(regWriteW),
        .loadE(resultSrcE == ctrlPkg::resMem), .pcSrcE(pcSrcE),
        .forwardAE(forwardAE), .forwardBE(forwardBE),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
    );

    // memory
    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSrcM <= ctrlPkg::resAlu;
        end else begin
            regWriteM  <= regWriteE;
            memWriteM  <= memWriteE;
            resultSrcM <= resultSrcE;
        end
    end

    always_ff @(posedge clk) begin
        rdM        <= rdE;
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        immM       <= immE;
    end

    assign dataAddr  = aluResultM;
    assign writeData = writeDataM;
    assign memWrite  = memWriteM;

    // lui and link values bypass the ALU result
    always_comb begin
        case (resultSrcM)
            ctrlPkg::resImm:     fwdValueM = immM;
            ctrlPkg::resPcPlus4: fwdValueM = pcPlus4M;
            default:             fwdValueM = aluResultM;
        endcase
    end

    // writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteW  <= 1'b0;
            resultSrcW <= ctrlPkg::resAlu;
        end else begin
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
        end
    end

    always_ff @(posedge clk) begin
        rdW        <= rdM;
        aluResultW <= aluResultM;
        readDataW  <= readData;
        pcPlus4W   <= pcPlus4M;
        immW       <= immM;
    end

    always_comb begin
        case (resultSrcW)
            ctrlPkg::resMem:     resultW = readDataW;
            ctrlPkg::resPcPlus4: resultW = pcPlus4W;
            ctrlPkg::resImm:     resultW = immW;
            default:             resultW = aluResultW;
        endcase
    end

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
    input  logic [4:0]         rs1D,
    input  logic [4:0]         rs2D,
    input  logic [4:0]         rs1E,
    input  logic [4:0]         rs2E,
    input  logic [4:0]         rdE,
    input  logic [4:0]         rdM,
    input  logic [4:0]         rdW,
    input  logic               regWriteM,
    input  logic               regWriteW,
    input  logic               loadE,
    input  ctrlPkg::pcSrc      pcSrcE,
    output ctrlPkg::forwardSel forwardAE,
    output ctrlPkg::forwardSel forwardBE,
    output logic               stallF,
    output logic               stallD,
    output logic               flushD,
    output logic               flushE
);

    logic loadStall;
    logic redirect;

    function automatic ctrlPkg::forwardSel pickSource(input logic [4:0] rs);
        if (rs != 5'd0 && regWriteM && rs == rdM) begin
            return ctrlPkg::fwdMemory;
        end
        if (rs != 5'd0 && regWriteW && rs == rdW) begin
            return ctrlPkg::fwdWriteback;
        end
        return ctrlPkg::fwdReg;
    endfunction

    assign forwardAE = pickSource(rs1E);
    assign forwardBE = pickSource(rs2E);

    // loaded word is not ready until writeback
    assign loadStall = loadE && rdE != 5'd0 && (rdE == rs1D || rdE == rs2D);
    assign redirect  = (pcSrcE != ctrlPkg::pcNext);

    assign stallF = loadStall;
    assign stallD = loadStall;
    assign flushD = redirect;
    assign flushE = redirect || loadStall;

    always_comb begin
        if (stallD) begin
            stallFlushExclusive: assert final (!flushD);
        end
        if (!regWriteM) begin
            noStaleMemForward: assert final (forwardAE != ctrlPkg::fwdMemory &&
                                             forwardBE != ctrlPkg::fwdMemory);
        end
    end

endmodule

`default_nettype wire

// ==== source/immExtend.sv ====
`timescale 1ns/100ps
`default_nettype none

module immExtend (
    input  isaPkg::instrWord instr,
    input  ctrlPkg::immKind  immSrc,
    output logic [31:0]      imm
);

    always_comb begin
        case (immSrc)
            ctrlPkg::immI: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            ctrlPkg::immS: imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            ctrlPkg::immB: begin
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            end
            ctrlPkg::immU: imm = {instr.u.imm, 12'b0};
            ctrlPkg::immJ: begin
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                       instr.j.imm11, instr.j.imm10to1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcode;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] op;
    } rType;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  op;
    } iType;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] op;
    } sType;

    // branch offset bits are scattered across the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] op;
    } bType;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  op;
    } uType;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] op;
    } jType;

    typedef union packed {
        rType r;
        iType i;
        sType s;
        bType b;
        uType u;
        jType j;
    } instrWord;

endpackage

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input  logic        clk,
    input  logic        regWrite,
    input  logic [4:0]  readRegister1,
    input  logic [4:0]  readRegister2,
    input  logic [4:0]  writeRegister,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (regWrite && writeRegister != 5'd0) begin
            regs[writeRegister] <= writeData;
        end
    end

    // write-before-read bypass
    always_comb begin
        if (readRegister1 == 5'd0) begin
            readData1 = '0;
        end else if (regWrite && readRegister1 == writeRegister) begin
            readData1 = writeData;
        end else begin
            readData1 = regs[readRegister1];
        end
    end

    always_comb begin
        if (readRegister2 == 5'd0) begin
            readData2 = '0;
        end else if (regWrite && readRegister2 == writeRegister) begin
            readData2 = writeData;
        end else begin
            readData2 = regs[readRegister2];
        end
    end

endmodule

`default_nettype wire

// ==== source/riscvCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscvCore #(
    parameter logic [31:0] resetAddress = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [31:0] dataAddr,
    output logic [31:0] writeData,
    output logic        memWrite,
    input  logic [31:0] readData
);

    logic [6:0]         op;
    logic [2:0]         funct3;
    logic               funct7b5;
    logic               regWriteD, memWriteD, aluSrcD, jumpD, jumpRegD;
    ctrlPkg::resultSrc  resultSrcD;
    ctrlPkg::aluCtrl    aluControlD;
    ctrlPkg::branchKind branchD;
    ctrlPkg::immKind    immSrcD;

    controller ctrl (
        .op(op), .funct3(funct3), .funct7b5(funct7b5),
        .regWriteD(regWriteD), .memWriteD(memWriteD), .aluSrcD(aluSrcD),
        .jumpD(jumpD), .jumpRegD(jumpRegD), .resultSrcD(resultSrcD),
        .aluControlD(aluControlD), .branchD(branchD), .immSrcD(immSrcD)
    );

    datapath #(.resetAddress(resetAddress)) path (
        .clk(clk), .rst(rst),
        .regWriteD(regWriteD), .memWriteD(memWriteD), .aluSrcD(aluSrcD),
        .jumpD(jumpD), .jumpRegD(jumpRegD), .resultSrcD(resultSrcD),
        .aluControlD(aluControlD), .branchD(branchD), .immSrcD(immSrcD),
        .op(op), .funct3(funct3), .funct7b5(funct7b5),
        .pc(pc), .instr(instr),
        .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite),
        .readData(readData)
    );

endmodule

`default_nettype wire
